// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = l2_cache_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/l2_cache_tb.sv ====
module l2_cache_tb
    import cache_geom_pkg::*;
    import cache_if_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        string       name;
        cache_req_t  req;
        logic [31:0] exp_rdata;
        bit          exp_refill;
    } test_t;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    logic         req_ready;
    cache_req_t   req;
    logic         resp_valid;
    logic         resp_ready;
    cache_resp_t  resp;
    logic         refill_req_valid;
    logic         refill_req_ready;
    refill_req_t  refill_req;
    logic         refill_resp_valid;
    logic         refill_resp_ready;
    refill_resp_t refill_resp;

    test_t       tests[$];
    bit          table_ready = 1'b0;
    logic [31:0] lcg_state = 32'h43708d63;
    int          refill_count = 0;
    line_addr_t  last_refill;

    // Reference cache contents
    logic [31:0]         ref_data  [num_sets][num_ways][words_per_line];
    logic [tag_bits-1:0] ref_tag   [num_sets][num_ways];
    bit                  ref_valid [num_sets][num_ways];
    logic [1:0]          ref_rr    [num_sets];

    l2_cache_top DUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Each memory word is its byte address with the upper half scrambled
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A50000;
    endfunction

    function automatic logic [line_bits-1:0] make_line(input line_addr_t la);
        logic [line_bits-1:0] line;
        for (int i = 0; i < words_per_line; i++) begin
            line[i*32 +: 32] = mem_word({la.tag, la.index, 4'(i), 2'b00});
        end
        return line;
    endfunction

    function automatic logic [31:0] word_addr(input logic [21:0] tag, input logic [3:0] set,
                                              input logic [3:0] off);
        return {tag, set, off, 2'b00};
    endfunction

    // Blocking cache that picks the lowest invalid way, then round robin, and drops evictions
    function automatic void ref_access(input cache_req_t r, output logic [31:0] rdata,
                                       output bit refill);
        logic [tag_bits-1:0] tag;
        logic [3:0]          set;
        logic [3:0]          off;
        logic [1:0]          way;
        bit                  found;
        tag   = r.addr[31:10];
        set   = r.addr[9:6];
        off   = r.addr[5:2];
        way   = 2'd0;
        found = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                found = 1'b1;
                way   = 2'(w);
            end
        end
        refill = !found;
        if (!found) begin
            way = ref_rr[set];
            for (int w = num_ways - 1; w >= 0; w--) begin
                if (!ref_valid[set][w]) begin
                    way = 2'(w);
                end
            end
            if (way == ref_rr[set]) begin
                ref_rr[set] = ref_rr[set] + 2'd1;
            end
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = tag;
            for (int i = 0; i < words_per_line; i++) begin
                ref_data[set][way][i] = mem_word({r.addr[31:6], 4'(i), 2'b00});
            end
        end
        rdata = ref_data[set][way][off];
        if (r.op == op_write) begin
            for (int b = 0; b < 4; b++) begin
                if (r.byte_en[b]) begin
                    rdata[b*8 +: 8] = r.wdata[b*8 +: 8];
                end
            end
            ref_data[set][way][off] = rdata;
        end
    endfunction

    task automatic add_test(input string name, input cache_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] byte_en);
        test_t       t;
        logic [31:0] exp_rdata;
        bit          exp_refill;
        t.name        = name;
        t.req.op      = op;
        t.req.addr    = addr;
        t.req.wdata   = wdata;
        t.req.byte_en = byte_en;
        ref_access(t.req, exp_rdata, exp_refill);
        t.exp_rdata  = exp_rdata;
        t.exp_refill = exp_refill;
        tests.push_back(t);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    task automatic build_table();
        logic [31:0] r;
        logic [31:0] wdata;
        for (int s = 0; s < num_sets; s++) begin
            ref_rr[s] = 2'd0;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        add_test("read_miss", op_read, word_addr(22'h1, 4'h2, 4'h3), 32'h0, 4'h0);
        add_test("read_hit", op_read, word_addr(22'h1, 4'h2, 4'h3), 32'h0, 4'h0);
        add_test("write_hit_partial", op_write, word_addr(22'h1, 4'h2, 4'h3), 32'h11223344, 4'h5);
        add_test("read_merged", op_read, word_addr(22'h1, 4'h2, 4'h3), 32'h0, 4'h0);
        add_test("read_neighbour_lo", op_read, word_addr(22'h1, 4'h2, 4'h2), 32'h0, 4'h0);
        add_test("read_neighbour_hi", op_read, word_addr(22'h1, 4'h2, 4'h4), 32'h0, 4'h0);
        add_test("write_miss", op_write, word_addr(22'h7, 4'h5, 4'h9), 32'hDEADBEEF, 4'h8);
        add_test("read_after_write_miss", op_read, word_addr(22'h7, 4'h5, 4'h9), 32'h0, 4'h0);
        // Five tags into set 10
        add_test("evict_write_t0", op_write, word_addr(22'h100, 4'hA, 4'h0), 32'h0BADF00D, 4'hF);
        add_test("evict_fill_t1", op_read, word_addr(22'h101, 4'hA, 4'h1), 32'h0, 4'h0);
        add_test("evict_fill_t2", op_read, word_addr(22'h102, 4'hA, 4'h1), 32'h0, 4'h0);
        add_test("evict_fill_t3", op_read, word_addr(22'h103, 4'hA, 4'h1), 32'h0, 4'h0);
        add_test("evict_t4_takes_way0", op_read, word_addr(22'h104, 4'hA, 4'h0), 32'h0, 4'h0);
        add_test("evict_t0_write_lost", op_read, word_addr(22'h100, 4'hA, 4'h0), 32'h0, 4'h0);
        add_test("evict_t4_still_hit", op_read, word_addr(22'h104, 4'hA, 4'h0), 32'h0, 4'h0);
        // Eight tags over two sets keep hits and evictions mixed
        for (int i = 0; i < 12; i++) begin
            r     = next_rand();
            wdata = next_rand();
            add_test($sformatf("random_%0d", i), r[0] ? op_write : op_read,
                     word_addr({19'd0, r[10:8]}, {3'd0, r[11]}, r[15:12]), wdata, r[19:16]);
        end
    endtask

    ////////////////////////////////////////
    // Memory model and back-pressure
    ////////////////////////////////////////
    initial begin : memory_model
        bit          req_hs;
        bit          resp_hs;
        bit          pending;
        int          delay;
        line_addr_t  pend_line;
        logic [31:0] r;
        resp_ready        = 1'b0;
        refill_req_ready  = 1'b0;
        refill_resp_valid = 1'b0;
        refill_resp       = '0;
        pending           = 1'b0;
        delay             = 0;
        forever begin
            // Sample the handshakes of the coming edge while everything is settled
            @(negedge clk);
            req_hs  = refill_req_valid && refill_req_ready;
            resp_hs = refill_resp_valid && refill_resp_ready;
            if (req_hs) begin
                refill_count++;
                last_refill = refill_req.line_addr;
            end
            @(posedge clk);
            #1;
            r                = next_rand();
            resp_ready       = (r[1:0] != 2'b00);
            refill_req_ready = (r[3:2] != 2'b00);
            if (resp_hs) begin
                refill_resp_valid = 1'b0;
            end
            if (req_hs) begin
                pending   = 1'b1;
                pend_line = last_refill;
                delay     = int'(r[5:4]);
            end else if (pending && delay > 0) begin
                delay--;
            end
            if (pending && delay == 0 && !refill_resp_valid) begin
                refill_resp.line  = make_line(pend_line);
                refill_resp_valid = 1'b1;
                pending           = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Request driver
    ////////////////////////////////////////
    task automatic send_request(input cache_req_t r);
        bit accepted;
        req       = r;
        req_valid = 1'b1;
        do begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #1;
        end while (!accepted);
        req_valid = 1'b0;
    endtask

    task automatic wait_response(output logic [31:0] rdata);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (resp_valid && resp_ready) begin
                done  = 1'b1;
                rdata = resp.rdata;
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 8 + tests.size() * 40;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        test_t       t;
        logic [31:0] rdata;
        line_addr_t  exp_line;
        int          count_before;
        int          delta;
        int          passed;
        int          failed;
        bit          ok;
        passed    = 0;
        failed    = 0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle outputs before the first request
        @(negedge clk);
        if (resp_valid !== 1'b0 || refill_req_valid !== 1'b0 || refill_resp_ready !== 1'b0 ||
            req_ready !== 1'b1) begin
            $display("reset_state: outputs not idle, req_ready=%b resp_valid=%b %s%b %s%b",
                     req_ready, resp_valid, "refill_req_valid=", refill_req_valid,
                     "refill_resp_ready=", refill_resp_ready);
            $display("FAIL reset_state");
            failed++;
        end else begin
            $display("pass reset_state");
            passed++;
        end
        @(posedge clk);
        #1;

        foreach (tests[i]) begin
            t            = tests[i];
            count_before = refill_count;
            send_request(t.req);
            wait_response(rdata);
            delta    = refill_count - count_before;
            exp_line = t.req.addr[31:6];
            ok       = 1'b1;
            if (rdata !== t.exp_rdata) begin
                $display("mismatch %s: expected %h, actual %h", t.name, t.exp_rdata, rdata);
                ok = 1'b0;
            end
            if (t.exp_refill && delta == 0) begin
                $display("%s: the line missed but no refill was requested", t.name);
                ok = 1'b0;
            end else if (!t.exp_refill && delta != 0) begin
                $display("%s: a refill was requested for a line that should hit", t.name);
                ok = 1'b0;
            end else if (delta > 1) begin
                $display("%s: %0d refills were requested for one miss", t.name, delta);
                ok = 1'b0;
            end else if (t.exp_refill && last_refill !== exp_line) begin
                $display("mismatch %s refill line: expected %h, actual %h",
                         t.name, exp_line, last_refill);
                ok = 1'b0;
            end
            if (ok) begin
                $display("pass %s", t.name);
                passed++;
            end else begin
                $display("FAIL %s", t.name);
                failed++;
            end
        end

        $display("%0d tests: %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/cache_geom_pkg.sv
hdl/cache_if_pkg.sv
hdl/bram_bytewrite.sv
hdl/l2_data_array.sv
hdl/l2_tag_array.sv
hdl/l2_cache_ctrl.sv
hdl/l2_cache_top.sv
dv/l2_cache_tb.sv

// ==== hdl/bram_bytewrite.sv ====
module bram_bytewrite
    import cache_geom_pkg::*;
#(
    parameter int data_width = line_bits,
    parameter int addr_width = index_bits
) (
    input  logic                    clk,

    input  logic [addr_width-1:0]   waddr,
    input  logic [data_width-1:0]   din,
    input  logic [data_width/8-1:0] we,

    input  logic [addr_width-1:0]   raddr,
    output logic [data_width-1:0]   dout
);

    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];

    // Per-byte write, old data seen by a read to the same address
    always_ff @(posedge clk) begin
        for (int b = 0; b < data_width / 8; b++) begin
            if (we[b]) begin
                mem[waddr][b*8 +: 8] <= din[b*8 +: 8];
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

// ==== hdl/cache_geom_pkg.sv ====
package cache_geom_pkg;

    ////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////
    localparam int num_ways       = 4;
    localparam int num_sets       = 16;
    localparam int line_bits      = 512;
    localparam int word_bits      = 32;
    localparam int words_per_line = line_bits / word_bits;
    localparam int index_bits     = 4;
    localparam int offset_bits    = 4;
    localparam int tag_bits       = 22;
    localparam int way_bits       = 2;

    ////////////////////////////////////////
    // Byte address fields, low bit of each
    ////////////////////////////////////////
    localparam int offset_lsb = 2;
    localparam int index_lsb  = offset_lsb + offset_bits;
    localparam int tag_lsb    = index_lsb + index_bits;

    // Names one line in the address space
    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] index;
    } line_addr_t;

endpackage

// ==== hdl/cache_if_pkg.sv ====
package cache_if_pkg;

    import cache_geom_pkg::*;

    ////////////////////////////////////////
    // Request and response channels
    ////////////////////////////////////////
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_e;

    typedef struct packed {
        cache_op_e              op;
        logic [31:0]            addr;
        logic [word_bits-1:0]   wdata;
        logic [word_bits/8-1:0] byte_en;
    } cache_req_t;

    // Merged word on a write, stored word on a read
    typedef struct packed {
        logic [word_bits-1:0] rdata;
    } cache_resp_t;

    ////////////////////////////////////////
    // Refill channels to memory
    ////////////////////////////////////////
    typedef struct packed {
        line_addr_t line_addr;
    } refill_req_t;

    typedef struct packed {
        logic [line_bits-1:0] line;
    } refill_resp_t;

endpackage

// ==== hdl/l2_cache_ctrl.sv ====
module l2_cache_ctrl
    import cache_geom_pkg::*;
    import cache_if_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,

    // Request and response
    input  logic                               req_valid,
    output logic                               req_ready,
    input  cache_req_t                         req,
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output cache_resp_t                        resp,

    // Refill channels
    output logic                               refill_req_valid,
    input  logic                               refill_req_ready,
    output refill_req_t                        refill_req,
    input  logic                               refill_resp_valid,
    output logic                               refill_resp_ready,
    input  refill_resp_t                       refill_resp,

    // Tag array
    output logic [index_bits-1:0]              lookup_index,
    output logic [tag_bits-1:0]                lookup_tag,
    input  logic [num_ways-1:0]                hit_way,
    input  logic [way_bits-1:0]                victim_way,
    output logic                               fill,
    output line_addr_t                         fill_addr,
    output logic [way_bits-1:0]                fill_way,

    // Data array
    output logic [index_bits-1:0]              data_raddr,
    input  logic [num_ways-1:0][line_bits-1:0] way_lines,
    output logic [index_bits-1:0]              data_waddr,
    output logic [offset_bits-1:0]             word_offset,
    output logic [word_bits-1:0]               word_data,
    output logic [word_bits/8-1:0]             byte_en,
    output logic [line_bits-1:0]               fill_line,
    output logic [num_ways-1:0]                way_we,
    output logic                               replace
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        compare,
        refill_request,
        refill_wait,
        respond
    } state_e;

    state_e               state_q, state_d;
    cache_req_t           req_q;
    cache_resp_t          resp_q;
    logic [way_bits-1:0]  victim_q;

    line_addr_t           req_line;
    logic [offset_bits-1:0] req_offset;
    logic                 hit;
    logic [line_bits-1:0] hit_line;
    logic [word_bits-1:0] hit_word;
    logic [word_bits-1:0] merged_word;

    assign req_line.tag   = req_q.addr[tag_lsb +: tag_bits];
    assign req_line.index = req_q.addr[index_lsb +: index_bits];
    assign req_offset     = req_q.addr[offset_lsb +: offset_bits];
    assign hit            = |hit_way;

    ////////////////////////////////////////
    // Hit way select and byte merge
    ////////////////////////////////////////
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                hit_line = way_lines[w];
            end
        end
    end

    assign hit_word = hit_line[req_offset * word_bits +: word_bits];

    always_comb begin
        merged_word = hit_word;
        for (int b = 0; b < word_bits / 8; b++) begin
            if (req_q.byte_en[b]) begin
                merged_word[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:           if (req_valid) state_d = lookup;
            lookup:         state_d = compare;
            compare:        state_d = hit ? respond : refill_request;
            refill_request: if (refill_req_ready) state_d = refill_wait;
            refill_wait:    if (refill_resp_valid) state_d = lookup;  // replay after fill
            respond:        if (resp_ready) state_d = idle;
            default:        state_d = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == idle && req_valid) begin
            req_q <= req;
        end
        if (state_q == compare && !hit) begin
            victim_q <= victim_way;
        end
        if (state_q == compare && hit) begin
            resp_q.rdata <= (req_q.op == op_write) ? merged_word : hit_word;
        end
    end

    ////////////////////////////////////////
    // Channel and array drives
    ////////////////////////////////////////
    assign req_ready         = (state_q == idle);
    assign resp_valid        = (state_q == respond);
    assign resp              = resp_q;
    assign refill_req_valid  = (state_q == refill_request);
    assign refill_req.line_addr = req_line;
    assign refill_resp_ready = (state_q == refill_wait);

    assign lookup_index = req_line.index;
    assign lookup_tag   = req_line.tag;
    // Tag and line land on the same edge
    assign fill         = refill_resp_ready && refill_resp_valid;
    assign fill_addr    = req_line;
    assign fill_way     = victim_q;

    assign data_raddr  = req_line.index;
    assign data_waddr  = req_line.index;
    assign word_offset = req_offset;
    assign word_data   = merged_word;
    assign byte_en     = req_q.byte_en;
    assign fill_line   = refill_resp.line;
    assign replace     = (state_q == refill_wait);

    always_comb begin
        way_we = '0;
        if (fill) begin
            way_we[victim_q] = 1'b1;
        end else if (state_q == compare && req_q.op == op_write) begin
            way_we = hit_way;
        end
    end

    a_resp_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp)
    );

    a_refill_req_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        refill_req_valid && !refill_req_ready |=> refill_req_valid && $stable(refill_req)
    );

endmodule

// ==== hdl/l2_cache_top.sv ====
module l2_cache_top
    import cache_geom_pkg::*;
    import cache_if_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         req_valid,
    output logic         req_ready,
    input  cache_req_t   req,

    output logic         resp_valid,
    input  logic         resp_ready,
    output cache_resp_t  resp,

    output logic         refill_req_valid,
    input  logic         refill_req_ready,
    output refill_req_t  refill_req,

    input  logic         refill_resp_valid,
    output logic         refill_resp_ready,
    input  refill_resp_t refill_resp
);

    ////////////////////////////////////////
    // Controller to arrays
    ////////////////////////////////////////
    logic [index_bits-1:0]              lookup_index;
    logic [tag_bits-1:0]                lookup_tag;
    logic [num_ways-1:0]                hit_way;
    logic [way_bits-1:0]                victim_way;
    logic                               fill;
    line_addr_t                         fill_addr;
    logic [way_bits-1:0]                fill_way;

    logic [index_bits-1:0]              data_raddr;
    logic [num_ways-1:0][line_bits-1:0] way_lines;
    logic [index_bits-1:0]              data_waddr;
    logic [offset_bits-1:0]             word_offset;
    logic [word_bits-1:0]               word_data;
    logic [word_bits/8-1:0]             byte_en;
    logic [line_bits-1:0]               fill_line;
    logic [num_ways-1:0]                way_we;
    logic                               replace;

    l2_cache_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid         (req_valid),
        .req_ready         (req_ready),
        .req               (req),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready),
        .resp              (resp),
        .refill_req_valid  (refill_req_valid),
        .refill_req_ready  (refill_req_ready),
        .refill_req        (refill_req),
        .refill_resp_valid (refill_resp_valid),
        .refill_resp_ready (refill_resp_ready),
        .refill_resp       (refill_resp),
        .lookup_index      (lookup_index),
        .lookup_tag        (lookup_tag),
        .hit_way           (hit_way),
        .victim_way        (victim_way),
        .fill              (fill),
        .fill_addr         (fill_addr),
        .fill_way          (fill_way),
        .data_raddr        (data_raddr),
        .way_lines         (way_lines),
        .data_waddr        (data_waddr),
        .word_offset       (word_offset),
        .word_data         (word_data),
        .byte_en           (byte_en),
        .fill_line         (fill_line),
        .way_we            (way_we),
        .replace           (replace)
    );

    l2_tag_array u_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .fill         (fill),
        .fill_addr    (fill_addr),
        .fill_way     (fill_way)
    );

    l2_data_array u_data (
        .clk         (clk),
        .raddr       (data_raddr),
        .way_lines   (way_lines),
        .waddr       (data_waddr),
        .word_offset (word_offset),
        .word_data   (word_data),
        .byte_en     (byte_en),
        .fill_line   (fill_line),
        .way_we      (way_we),
        .replace     (replace)
    );

endmodule

// ==== hdl/l2_data_array.sv ====
module l2_data_array
    import cache_geom_pkg::*;
(
    input  logic                                clk,

    // Read side, all four ways at once
    input  logic [index_bits-1:0]               raddr,
    output logic [num_ways-1:0][line_bits-1:0]  way_lines,

    // Write side
    input  logic [index_bits-1:0]               waddr,
    input  logic [offset_bits-1:0]              word_offset,
    input  logic [word_bits-1:0]                word_data,
    input  logic [word_bits/8-1:0]              byte_en,
    input  logic [line_bits-1:0]                fill_line,
    input  logic [num_ways-1:0]                 way_we,
    input  logic                                replace
);

    localparam int line_bytes = line_bits / 8;
    localparam int word_bytes = word_bits / 8;

    logic [line_bytes-1:0] word_be;
    logic [line_bits-1:0]  din;

    ////////////////////////////////////////
    // Write data and byte enable steering
    ////////////////////////////////////////
    always_comb begin
        // Word lanes shifted to the word offset
        word_be = {{(line_bytes - word_bytes){1'b0}}, byte_en} << (word_offset * word_bytes);
        if (replace) begin
            din = fill_line;
        end else begin
            din = {{(line_bits - word_bits){1'b0}}, word_data} << (word_offset * word_bits);
        end
    end

    ////////////////////////////////////////
    // One RAM per way
    ////////////////////////////////////////
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        logic [line_bytes-1:0] we;

        always_comb begin
            if (!way_we[w]) begin
                we = '0;
            end else if (replace) begin
                we = '1;
            end else begin
                we = word_be;
            end
        end

        bram_bytewrite #(
            .data_width (line_bits),
            .addr_width (index_bits)
        ) u_bram (
            .clk   (clk),
            .waddr (waddr),
            .din   (din),
            .we    (we),
            .raddr (raddr),
            .dout  (way_lines[w])
        );
    end

    // Controller never writes two ways in one cycle
    a_way_we_onehot : assert property (
        @(posedge clk) !$isunknown(way_we) |-> $onehot0(way_we)
    );

endmodule

// ==== hdl/l2_tag_array.sv ====
module l2_tag_array
    import cache_geom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // Lookup, results one cycle later
    input  logic [index_bits-1:0] lookup_index,
    input  logic [tag_bits-1:0]   lookup_tag,
    output logic [num_ways-1:0]   hit_way,
    output logic [way_bits-1:0]   victim_way,

    // Fill after a refill
    input  logic                  fill,
    input  line_addr_t            fill_addr,
    input  logic [way_bits-1:0]   fill_way
);

    logic [tag_bits-1:0] tags_q  [num_sets][num_ways];
    logic [num_ways-1:0] valid_q [num_sets];
    logic [way_bits-1:0] rr_q    [num_sets];

    logic [num_ways-1:0] hit_next;
    logic [way_bits-1:0] victim_next;

    ////////////////////////////////////////
    // Compare and victim choice
    ////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_next[w] = valid_q[lookup_index][w] && (tags_q[lookup_index][w] == lookup_tag);
        end
    end

    // Lowest invalid way wins, else the set's pointer
    always_comb begin
        victim_next = rr_q[lookup_index];
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_q[lookup_index][w]) begin
                victim_next = way_bits'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_way    <= '0;
            victim_way <= '0;
        end else begin
            hit_way    <= hit_next;
            victim_way <= victim_next;
        end
    end

    ////////////////////////////////////////
    // Fill
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill) begin
            valid_q[fill_addr.index][fill_way] <= 1'b1;
            // Pointer moves only past the way it names
            if (fill_way == rr_q[fill_addr.index]) begin
                rr_q[fill_addr.index] <= rr_q[fill_addr.index] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags_q[fill_addr.index][fill_way] <= fill_addr.tag;
        end
    end

    // A tag is only filled after it missed, so no set holds it twice
    a_hit_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(hit_way)
    );

endmodule
